//--- design/rv_core_pkg.sv
package rv_core_pkg;

    localparam int XLEN       = 64;
    localparam int REG_ADDR_W = 5;

    localparam logic [6:0] OP        = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_32     = 7'b0111011;
    localparam logic [6:0] OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] LUI       = 7'b0110111;
    localparam logic [6:0] AUIPC     = 7'b0010111;
    localparam logic [6:0] JAL       = 7'b1101111;
    localparam logic [6:0] JALR      = 7'b1100111;
    localparam logic [6:0] BRANCH    = 7'b1100011;

    typedef enum logic [4:0] {
        ALU_ADD    = 5'd0,
        ALU_SUB    = 5'd1,
        ALU_SLL    = 5'd2,
        ALU_SLT    = 5'd3,
        ALU_SLTU   = 5'd4,
        ALU_XOR    = 5'd5,
        ALU_SRL    = 5'd6,
        ALU_SRA    = 5'd7,
        ALU_OR     = 5'd8,
        ALU_AND    = 5'd9,
        ALU_PASS_B = 5'd10, // lui
        ALU_ADDW   = 5'd11,
        ALU_SUBW   = 5'd12,
        ALU_SLLW   = 5'd13,
        ALU_SRLW   = 5'd14,
        ALU_SRAW   = 5'd15
    } alu_op_e;

    typedef enum logic [1:0] {
        OPA_RS1  = 2'd0,
        OPA_PC   = 2'd1,
        OPA_ZERO = 2'd2
    } opa_sel_e;

    typedef enum logic [1:0] {
        OPB_RS2  = 2'd0,
        OPB_IMM  = 2'd1,
        OPB_FOUR = 2'd2
    } opb_sel_e;

    typedef enum logic [2:0] {
        BR_NONE = 3'd0, // must stay zero, flush relies on it
        BR_EQ   = 3'd1,
        BR_NE   = 3'd2,
        BR_LT   = 3'd3,
        BR_GE   = 3'd4,
        BR_LTU  = 3'd5,
        BR_GEU  = 3'd6
    } br_cond_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_r_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } instr_i_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } instr_s_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } instr_b_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } instr_u_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_j_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
        instr_s_t s;
        instr_b_t b;
        instr_u_t u;
        instr_j_t j;
    } instr_u;

    typedef struct packed {
        logic                  valid;
        alu_op_e               alu_op;
        opa_sel_e              opa_sel;
        opb_sel_e              opb_sel;
        br_cond_e              br_cond;
        logic                  jal;
        logic                  jalr;
        logic                  write_rd;
        logic [REG_ADDR_W-1:0] rs1addr;
        logic [REG_ADDR_W-1:0] rs2addr;
        logic [REG_ADDR_W-1:0] rwaddr;
        logic [XLEN-1:0]       imm;
        logic [XLEN-1:0]       pc;
    } id_ctrl_t;

    typedef struct packed {
        id_ctrl_t        ctrl;
        logic [XLEN-1:0] rs1_data;
        logic [XLEN-1:0] rs2_data;
    } id_ex_t;

    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } wb_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] target;
    } redirect_t;

endpackage

//--- design/id_decode.sv
module id_decode import rv_core_pkg::*; (
    input  instr_u          instr_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic            valid_i,
    output id_ctrl_t        ctrl_o
);

    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_j;
    logic [2:0]      f3;
    logic            alt; // instr bit 30
    logic            known;

    assign f3  = instr_i.r.funct3;
    assign alt = instr_i.r.funct7[5];

    assign imm_i = {{(XLEN-12){instr_i.i.imm_11_0[11]}}, instr_i.i.imm_11_0};
    assign imm_u = {{(XLEN-32){instr_i.u.imm_31_12[19]}}, instr_i.u.imm_31_12, 12'b0};
    assign imm_b = {{(XLEN-13){instr_i.b.imm_12}}, instr_i.b.imm_12, instr_i.b.imm_11,
                    instr_i.b.imm_10_5, instr_i.b.imm_4_1, 1'b0};
    assign imm_j = {{(XLEN-21){instr_i.j.imm_20}}, instr_i.j.imm_20, instr_i.j.imm_19_12,
                    instr_i.j.imm_11, instr_i.j.imm_10_1, 1'b0};

    // shared by OP and OP_IMM, sub only exists for the register form
    function automatic alu_op_e base_op(input logic [2:0] fn, input logic a, input logic is_reg);
        case (fn)
            3'b000:  base_op = (a && is_reg) ? ALU_SUB : ALU_ADD;
            3'b001:  base_op = ALU_SLL;
            3'b010:  base_op = ALU_SLT;
            3'b011:  base_op = ALU_SLTU;
            3'b100:  base_op = ALU_XOR;
            3'b101:  base_op = a ? ALU_SRA : ALU_SRL;
            3'b110:  base_op = ALU_OR;
            default: base_op = ALU_AND;
        endcase
    endfunction

    always_comb begin
        ctrl_o         = '0;
        known          = 1'b1;
        ctrl_o.pc      = pc_i;
        ctrl_o.rs1addr = instr_i.r.rs1;
        ctrl_o.rs2addr = instr_i.s.rs2;
        ctrl_o.rwaddr  = instr_i.r.rd;
        ctrl_o.alu_op  = ALU_ADD;
        ctrl_o.opa_sel = OPA_RS1;
        ctrl_o.opb_sel = OPB_RS2;
        ctrl_o.br_cond = BR_NONE;
        case (instr_i.r.opcode)
            OP, OP_IMM: begin
                ctrl_o.alu_op   = base_op(f3, alt, instr_i.r.opcode == OP);
                ctrl_o.opb_sel  = (instr_i.r.opcode == OP) ? OPB_RS2 : OPB_IMM;
                ctrl_o.imm      = imm_i;
                ctrl_o.write_rd = 1'b1;
            end
            OP_32, OP_IMM_32: begin
                case (f3)
                    3'b000: begin
                        ctrl_o.alu_op = (alt && instr_i.r.opcode == OP_32) ? ALU_SUBW : ALU_ADDW;
                    end
                    3'b001:  ctrl_o.alu_op = ALU_SLLW;
                    3'b101:  ctrl_o.alu_op = alt ? ALU_SRAW : ALU_SRLW;
                    default: known = 1'b0;
                endcase
                ctrl_o.opb_sel  = (instr_i.r.opcode == OP_32) ? OPB_RS2 : OPB_IMM;
                ctrl_o.imm      = imm_i;
                ctrl_o.write_rd = 1'b1;
            end
            LUI: begin
                ctrl_o.alu_op   = ALU_PASS_B;
                ctrl_o.opa_sel  = OPA_ZERO;
                ctrl_o.opb_sel  = OPB_IMM;
                ctrl_o.imm      = imm_u;
                ctrl_o.write_rd = 1'b1;
            end
            AUIPC: begin
                ctrl_o.opa_sel  = OPA_PC;
                ctrl_o.opb_sel  = OPB_IMM;
                ctrl_o.imm      = imm_u;
                ctrl_o.write_rd = 1'b1;
            end
            JAL, JALR: begin
                ctrl_o.jal      = (instr_i.r.opcode == JAL);
                ctrl_o.jalr     = (instr_i.r.opcode == JALR);
                ctrl_o.opa_sel  = OPA_PC; // link value pc+4
                ctrl_o.opb_sel  = OPB_FOUR;
                ctrl_o.imm      = (instr_i.r.opcode == JAL) ? imm_j : imm_i;
                ctrl_o.write_rd = 1'b1;
            end
            BRANCH: begin
                ctrl_o.imm = imm_b;
                case (f3)
                    3'b000:  ctrl_o.br_cond = BR_EQ;
                    3'b001:  ctrl_o.br_cond = BR_NE;
                    3'b100:  ctrl_o.br_cond = BR_LT;
                    3'b101:  ctrl_o.br_cond = BR_GE;
                    3'b110:  ctrl_o.br_cond = BR_LTU;
                    3'b111:  ctrl_o.br_cond = BR_GEU;
                    default: known = 1'b0;
                endcase
            end
            default: known = 1'b0;
        endcase
        ctrl_o.valid    = valid_i & known;
        ctrl_o.write_rd = ctrl_o.write_rd & ctrl_o.valid & (ctrl_o.rwaddr != '0);
    end

endmodule

//--- design/reg_file.sv
module reg_file import rv_core_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic [REG_ADDR_W-1:0] rs1addr_i,
    input  logic [REG_ADDR_W-1:0] rs2addr_i,
    input  wb_t                   wb_i,
    output logic [XLEN-1:0]       rs1_data_o,
    output logic [XLEN-1:0]       rs2_data_o
);

    logic [XLEN-1:0] regs [2**REG_ADDR_W];
    logic            wr_en;

    assign wr_en = wb_i.valid && (wb_i.rd != '0);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int k = 0; k < 2**REG_ADDR_W; k++) begin
                regs[k] <= '0;
            end
        end else if (wr_en) begin
            regs[wb_i.rd] <= wb_i.data;
        end
    end

    // write-through so a same-cycle write is seen by ID
    function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] addr);
        if (wr_en && wb_i.rd == addr) begin
            read_port = wb_i.data;
        end else begin
            read_port = regs[addr];
        end
    endfunction

    assign rs1_data_o = read_port(rs1addr_i);
    assign rs2_data_o = read_port(rs2addr_i);

endmodule

//--- design/operand_fwd.sv
module operand_fwd import rv_core_pkg::*; (
    input  logic [REG_ADDR_W-1:0] rs1addr_i,
    input  logic [REG_ADDR_W-1:0] rs2addr_i,
    input  logic [XLEN-1:0]       rf_rs1_i,
    input  logic [XLEN-1:0]       rf_rs2_i,
    input  logic [REG_ADDR_W-1:0] ex_rd_i,
    input  logic                  ex_write_i,
    input  logic [XLEN-1:0]       ex_result_i,
    input  wb_t                   wb_i,
    output logic [XLEN-1:0]       rs1_data_o,
    output logic [XLEN-1:0]       rs2_data_o
);

    // newest producer wins: EX, then WB, then the file
    function automatic logic [XLEN-1:0] pick(
        input logic [REG_ADDR_W-1:0] addr,
        input logic [XLEN-1:0]       rf_data
    );
        if (addr == '0) begin
            pick = '0;
        end else if (ex_write_i && ex_rd_i == addr) begin
            pick = ex_result_i;
        end else if (wb_i.valid && wb_i.rd == addr) begin
            pick = wb_i.data;
        end else begin
            pick = rf_data;
        end
    endfunction

    assign rs1_data_o = pick(rs1addr_i, rf_rs1_i);
    assign rs2_data_o = pick(rs2addr_i, rf_rs2_i);

endmodule

//--- design/id_ex_reg.sv
module id_ex_reg import rv_core_pkg::*; (
    input  logic   clk_i,
    input  logic   rst_n_i,
    input  logic   flush_i,
    input  logic   bubble_i,
    input  id_ex_t d_i,
    output id_ex_t q_o
);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            q_o <= '0; // no-op
        end else if (flush_i) begin
            q_o <= '0; // squash the wrong-path instr
        end else if (!bubble_i) begin
            q_o <= d_i;
        end
    end

    // redirect is suppressed while stalled
    a_no_flush_in_stall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(flush_i && bubble_i));

endmodule

//--- design/ex_stage.sv
module ex_stage import rv_core_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  stall_i,
    input  id_ex_t                idex_i,
    output logic [REG_ADDR_W-1:0] ex_rd_o,
    output logic                  ex_write_o,
    output logic [XLEN-1:0]       ex_result_o,
    output redirect_t             redirect_o,
    output wb_t                   wb_o
);

    id_ctrl_t              ctrl;
    logic [XLEN-1:0]       op_a;
    logic [XLEN-1:0]       op_b;
    logic                  taken;
    logic                  live;
    logic [XLEN-1:0]       jalr_sum;
    logic                  wb_valid_q;
    logic [REG_ADDR_W-1:0] wb_rd_q;
    logic [XLEN-1:0]       wb_data_q;

    assign ctrl = idex_i.ctrl;
    assign live = ctrl.valid & ~stall_i;

    always_comb begin
        case (ctrl.opa_sel)
            OPA_RS1: op_a = idex_i.rs1_data;
            OPA_PC:  op_a = ctrl.pc;
            default: op_a = '0;
        endcase
        case (ctrl.opb_sel)
            OPB_RS2: op_b = idex_i.rs2_data;
            OPB_IMM: op_b = ctrl.imm;
            default: op_b = XLEN'(4);
        endcase
    end

    function automatic logic [XLEN-1:0] sext_w(input logic [31:0] v);
        sext_w = {{(XLEN-32){v[31]}}, v};
    endfunction

    function automatic logic [XLEN-1:0] alu(
        input alu_op_e         op,
        input logic [XLEN-1:0] a,
        input logic [XLEN-1:0] b
    );
        case (op)
            ALU_ADD:    alu = a + b;
            ALU_SUB:    alu = a - b;
            ALU_SLL:    alu = a << b[5:0];
            ALU_SLT:    alu = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU:   alu = {{(XLEN-1){1'b0}}, a < b};
            ALU_XOR:    alu = a ^ b;
            ALU_SRL:    alu = a >> b[5:0];
            ALU_SRA:    alu = $signed(a) >>> b[5:0];
            ALU_OR:     alu = a | b;
            ALU_AND:    alu = a & b;
            ALU_PASS_B: alu = b;
            ALU_ADDW:   alu = sext_w(a[31:0] + b[31:0]);
            ALU_SUBW:   alu = sext_w(a[31:0] - b[31:0]);
            ALU_SLLW:   alu = sext_w(a[31:0] << b[4:0]);
            ALU_SRLW:   alu = sext_w(a[31:0] >> b[4:0]);
            ALU_SRAW:   alu = sext_w($signed(a[31:0]) >>> b[4:0]);
            default:    alu = '0;
        endcase
    endfunction

    assign ex_result_o = alu(ctrl.alu_op, op_a, op_b);
    assign ex_rd_o     = ctrl.rwaddr;
    assign ex_write_o  = ctrl.valid & ctrl.write_rd;

    always_comb begin
        case (ctrl.br_cond)
            BR_EQ:   taken = idex_i.rs1_data == idex_i.rs2_data;
            BR_NE:   taken = idex_i.rs1_data != idex_i.rs2_data;
            BR_LT:   taken = $signed(idex_i.rs1_data) < $signed(idex_i.rs2_data);
            BR_GE:   taken = $signed(idex_i.rs1_data) >= $signed(idex_i.rs2_data);
            BR_LTU:  taken = idex_i.rs1_data < idex_i.rs2_data;
            BR_GEU:  taken = idex_i.rs1_data >= idex_i.rs2_data;
            default: taken = 1'b0;
        endcase
    end

    assign jalr_sum = idex_i.rs1_data + ctrl.imm;

    assign redirect_o.valid  = live & (ctrl.jal | ctrl.jalr | taken);
    assign redirect_o.target = ctrl.jalr ? {jalr_sum[XLEN-1:1], 1'b0} : ctrl.pc + ctrl.imm;

    // valid is a one-shot, rd and data keep the last result across a stall
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_valid_q <= 1'b0;
        end else begin
            wb_valid_q <= live & ctrl.write_rd;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            wb_rd_q   <= ctrl.rwaddr;
            wb_data_q <= ex_result_o;
        end
    end

    assign wb_o.valid = wb_valid_q;
    assign wb_o.rd    = wb_rd_q;
    assign wb_o.data  = wb_data_q;

    a_target_align: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        redirect_o.valid |-> redirect_o.target[1:0] == 2'b00);

endmodule

//--- design/rv_idex_top.sv
module rv_idex_top import rv_core_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  instr_u          instr_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic            valid_i,
    input  logic            stall_i,
    output wb_t             wb_o,
    output redirect_t       redirect_o
);

    id_ctrl_t              id_ctrl;
    logic [XLEN-1:0]       rf_rs1;
    logic [XLEN-1:0]       rf_rs2;
    logic [XLEN-1:0]       fwd_rs1;
    logic [XLEN-1:0]       fwd_rs2;
    id_ex_t                idex_d;
    id_ex_t                idex_q;
    logic [REG_ADDR_W-1:0] ex_rd;
    logic                  ex_write;
    logic [XLEN-1:0]       ex_result;

    id_decode i_decode (
        .instr_i (instr_i),
        .pc_i    (pc_i),
        .valid_i (valid_i),
        .ctrl_o  (id_ctrl)
    );

    reg_file i_rf (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .rs1addr_i  (id_ctrl.rs1addr),
        .rs2addr_i  (id_ctrl.rs2addr),
        .wb_i       (wb_o),
        .rs1_data_o (rf_rs1),
        .rs2_data_o (rf_rs2)
    );

    operand_fwd i_fwd (
        .rs1addr_i   (id_ctrl.rs1addr),
        .rs2addr_i   (id_ctrl.rs2addr),
        .rf_rs1_i    (rf_rs1),
        .rf_rs2_i    (rf_rs2),
        .ex_rd_i     (ex_rd),
        .ex_write_i  (ex_write),
        .ex_result_i (ex_result),
        .wb_i        (wb_o),
        .rs1_data_o  (fwd_rs1),
        .rs2_data_o  (fwd_rs2)
    );

    assign idex_d = '{ctrl: id_ctrl, rs1_data: fwd_rs1, rs2_data: fwd_rs2};

    id_ex_reg i_idex (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .flush_i  (redirect_o.valid), // drop instr in ID on a taken redirect
        .bubble_i (stall_i),
        .d_i      (idex_d),
        .q_o      (idex_q)
    );

    ex_stage i_ex (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .stall_i     (stall_i),
        .idex_i      (idex_q),
        .ex_rd_o     (ex_rd),
        .ex_write_o  (ex_write),
        .ex_result_o (ex_result),
        .redirect_o  (redirect_o),
        .wb_o        (wb_o)
    );

endmodule

//--- tests/tb_rv_idex.sv
module tb_rv_idex import rv_core_pkg::*; ();

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [31:0]     instr;
        logic            valid;
        logic            stall;
    } stim_t;

    logic            clk;
    logic            rst_n;
    instr_u          instr;
    logic [XLEN-1:0] pc;
    logic            valid;
    logic            stall;
    wb_t             wb;
    redirect_t       redirect;

    stim_t     stim_q[$];
    wb_t       wb_exp_q[$];
    redirect_t redir_exp_q[$];
    int        cycle_limit = 0;
    int        bad_lines;

    rv_idex_top i_dut (
        .clk_i      (clk),
        .rst_n_i    (rst_n),
        .instr_i    (instr),
        .pc_i       (pc),
        .valid_i    (valid),
        .stall_i    (stall),
        .wb_o       (wb),
        .redirect_o (redirect)
    );

    always #5 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic read_trace(output int bad);
        int              fd;
        int              n;
        string           line;
        logic [XLEN-1:0] f_pc;
        logic [31:0]     f_word;
        logic            f_valid;
        logic            f_stall;
        logic [4:0]      f_rd;
        logic [XLEN-1:0] f_data;
        stim_t           s;
        wb_t             w;
        redirect_t       r;
        bad = 0;
        fd = $fopen("tests/idex_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open tests/idex_trace.txt");
            bad = 1;
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 1 && line[0] == "I") begin
                    n = $sscanf(line, "I %h %h %h %h", f_pc, f_word, f_valid, f_stall);
                    s.pc    = f_pc;
                    s.instr = f_word;
                    s.valid = f_valid;
                    s.stall = f_stall;
                    stim_q.push_back(s);
                    bad += (n != 4);
                end else if (n > 1 && line[0] == "W") begin
                    n = $sscanf(line, "W %h %h", f_rd, f_data);
                    w.valid = 1'b1;
                    w.rd    = f_rd;
                    w.data  = f_data;
                    wb_exp_q.push_back(w);
                    bad += (n != 2);
                end else if (n > 1 && line[0] == "R") begin
                    n = $sscanf(line, "R %h", f_data);
                    r.valid  = 1'b1;
                    r.target = f_data;
                    redir_exp_q.push_back(r);
                    bad += (n != 1);
                end else if (n > 1 && line[0] != "#") begin
                    $display("trace line not understood: %s", line);
                    bad++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic drive_stim(input stim_t s);
        @(posedge clk);
        instr <= s.instr;
        pc    <= s.pc;
        valid <= s.valid;
        stall <= s.stall;
    endtask

    task automatic check_wb(input wb_t act);
        wb_t exp;
        if (wb_exp_q.size() == 0) begin
            abort_run($sformatf("unexpected writeback to x%0d at time %0t", act.rd, $time));
        end else begin
            exp = wb_exp_q.pop_front();
            if (act !== exp) begin
                abort_run($sformatf("Error: wb_o expected rd=%h data=%h, got rd=%h data=%h",
                    exp.rd, exp.data, act.rd, act.data));
            end
        end
    endtask

    task automatic check_redirect(input redirect_t act);
        redirect_t exp;
        if (redir_exp_q.size() == 0) begin
            abort_run($sformatf("unexpected redirect to %h at time %0t", act.target, $time));
        end else begin
            exp = redir_exp_q.pop_front();
            if (act !== exp) begin
                abort_run($sformatf("Error: redirect_o expected target=%h, got target=%h",
                    exp.target, act.target));
            end
        end
    endtask

    task automatic run_program();
        stim_t idle;
        idle = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        while (stim_q.size() > 0) begin
            drive_stim(stim_q.pop_front());
        end
        drive_stim(idle);
        repeat (4) @(posedge clk); // last result is 2 cycles behind its instr
        if (wb_exp_q.size() != 0 || redir_exp_q.size() != 0) begin
            abort_run($sformatf("%0d writebacks and %0d redirects never showed up",
                wb_exp_q.size(), redir_exp_q.size()));
        end else begin
            $display("Everything OK");
            $finish;
        end
    endtask

    // sampled away from the driving edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (wb.valid) begin
                check_wb(wb);
            end
            if (redirect.valid) begin
                check_redirect(redirect);
            end
        end
    end

    initial begin
        wait (cycle_limit > 0);
        repeat (cycle_limit) @(posedge clk);
        abort_run($sformatf("Timeout: run did not end within %0d cycles", cycle_limit));
    end

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        instr = '0;
        pc    = '0;
        valid = 1'b0;
        stall = 1'b0;
        read_trace(bad_lines);
        if (bad_lines != 0) begin
            abort_run($sformatf("trace file unusable, %0d bad lines", bad_lines));
        end else begin
            cycle_limit = stim_q.size() + 20;
            run_program();
        end
    end

endmodule

//--- tests/idex_trace.txt
# I pc instr valid stall: one line per clock | W rd data: expected writeback
# R target: expected redirect | all fields hex, expectations in program order
I 1000 00500093 1 0
W 01 0000000000000005
I 1004 ffd08113 1 0
W 02 0000000000000002
I 1008 402081b3 1 0
W 03 0000000000000003
I 100c 80000237 1 0
W 04 ffffffff80000000
I 1010 fff2029b 1 0
W 05 000000007fffffff
I 1014 0012833b 1 0
W 06 ffffffff80000004
I 1018 03e19393 1 0
W 07 c000000000000000
I 101c 43c3d413 1 0
W 08 fffffffffffffffc
I 1020 001424b3 1 0
W 09 0000000000000001
I 1024 00143533 1 0
W 0a 0000000000000000
I 1028 006445b3 1 0
W 0b 000000007ffffff8
I 102c 0025e633 1 1
I 102c 0025e633 1 1
I 102c 0025e633 1 0
W 0c 000000007ffffffa
I 1030 0f067693 1 0
W 0d 00000000000000f0
I 1034 00001717 1 0
W 0e 0000000000002034
I 1038 00700013 1 0
I 103c 00d007b3 1 0
W 0f 00000000000000f0
I 1040 00208463 1 0
I 1044 00209863 1 0
R 0000000000001054
I 1048 12300813 1 0
I 1054 00c008ef 1 0
R 0000000000001060
W 11 0000000000001058
I 1058 12300813 1 0
I 1060 01170967 1 0
R 0000000000002044
W 12 0000000000001064
I 1064 12300813 1 0
I 2044 012889b3 1 0
W 13 00000000000020bc
I 2048 40100a3b 1 0
W 14 fffffffffffffffb
I 204c 40135abb 1 0
W 15 fffffffffc000000

//--- rv_idex.f
design/rv_core_pkg.sv
design/id_decode.sv
design/reg_file.sv
design/operand_fwd.sv
design/id_ex_reg.sv
design/ex_stage.sv
design/rv_idex_top.sv
tests/tb_rv_idex.sv

//--- Makefile
SIM      := verilator
TOP      := tb_rv_idex
FILELIST := rv_idex.f
OBJ_DIR  := obj_dir
FLAGS    := --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
